/* flist.f */
+incdir+include
design/uart_dbg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/dbg_mem.sv
design/dbg_cmd_fsm.sv
design/uart_dbg_top.sv
tb/tb_uart_dbg.sv

/* run_sim.sh */
#!/bin/sh
# Build the loader testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_uart_dbg -o tb_uart_dbg \
  && ./obj_dir/tb_uart_dbg > "$LOG" 2>&1 \
  || { echo "build or simulation run failed"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "SIMULATION PASSED" "$LOG" \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

/* include/tb_uart_tasks.svh */
// Host side of the loader serial link
// Sends 8N1 bytes on uart_rx_i, decodes 8N1 bytes from uart_tx_o
// and holds the model of the 256-byte loader memory.

`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Model memory, the 8-bit index wraps like the loader pointer
uart_dbg_pkg::byte_t model_mem [uart_dbg_pkg::MEM_DEPTH];

// One frame, start bit first, each bit held for one bit period
task automatic send_byte(input uart_dbg_pkg::byte_t b);
  logic [9:0] frame;
  frame = {1'b1, b, 1'b0};
  repeat (10) begin
    @(posedge clk);
    uart_rx_i <= frame[0];
    frame = frame >> 1;
    repeat (uart_dbg_pkg::CLKS_PER_BIT - 1) @(posedge clk);
  end
endtask

// Command byte, address LSB first, then length when the request has one
task automatic issue_request(input uart_dbg_pkg::byte_t cmd,
                             input uart_dbg_pkg::dbg_addr_t addr,
                             input logic [63:0] len,
                             input bit with_len);
  logic [63:0] a;
  logic [63:0] l;
  a = addr;
  l = len;
  send_byte(cmd);
  repeat (uart_dbg_pkg::HDR_BYTES) begin
    send_byte(a[7:0]);
    a = a >> 8;
  end
  if (with_len) begin
    repeat (uart_dbg_pkg::HDR_BYTES) begin
      send_byte(l[7:0]);
      l = l >> 8;
    end
  end
endtask

// Samples on falling edges, away from the DUT's launch edge
task automatic recv_byte(output uart_dbg_pkg::byte_t b);
  uart_dbg_pkg::byte_t data;
  data = '0;
  do begin
    @(negedge clk);
  end while (uart_tx_o !== 1'b0);
  // Middle of the start bit
  repeat (uart_dbg_pkg::CLKS_PER_BIT / 2) @(negedge clk);
  repeat (8) begin
    repeat (uart_dbg_pkg::CLKS_PER_BIT) @(negedge clk);
    data = {uart_tx_o, data[7:1]};
  end
  repeat (uart_dbg_pkg::CLKS_PER_BIT) @(negedge clk);
  if (uart_tx_o !== 1'b1) begin
    failure("stop bit on uart_tx_o was not high, the reply frame is broken");
  end
  b = data;
endtask

`endif

/* tb/tb_uart_dbg.sv */
// UART debug loader testbench
// Plays the host side of the boot protocol: challenge, write,
// read back with address wrap, zero length and exec. Replies
// are decoded from the serial output and checked against a model.

`timescale 1ns/100ps
`default_nettype none

module tb_uart_dbg;

  localparam int FRAME_CLKS = 10 * uart_dbg_pkg::CLKS_PER_BIT;
  localparam int MAX_LEN    = 40;
  localparam int REQ_BYTES  = 2 * uart_dbg_pkg::HDR_BYTES + 1;
  // Wire bytes of all tests in both directions, at the longest length
  localparam int RUN_BYTES  = 3 + 4 * (REQ_BYTES + MAX_LEN + 2) + 2 * (REQ_BYTES + 2)
                            + uart_dbg_pkg::HDR_BYTES + 2;
  localparam int QUIET_FRAMES = 30;
  localparam int WATCH_NS = (RUN_BYTES + QUIET_FRAMES) * FRAME_CLKS * 20 * 3 / 2 + 16 * 20;

  logic                    clk;
  logic                    rst_n_i;
  logic                    uart_rx_i;
  logic                    uart_tx_o;
  logic                    exec_valid_o;
  uart_dbg_pkg::dbg_addr_t exec_addr_o;

  uart_dbg_pkg::byte_t     rx_q [$];
  uart_dbg_pkg::byte_t     exp_q [$];
  uart_dbg_pkg::dbg_addr_t exp_entry;
  uart_dbg_pkg::dbg_addr_t exec_seen;
  logic                    quiet_expected;
  int                      exec_cnt = 0;
  int                      errors = 0;
  int                      tests_run = 0;
  int                      tests_failed = 0;
  int                      errors_at_open;
  string                   cur_test;

  `include "tb_uart_tasks.svh"

  uart_dbg_top dut_i (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Reporting and reply checks
  ////////////////////////////////////////

  function automatic void mismatch(input string msg);
    errors++;
    $display("error @ %0t ns: %s", $time, msg);
  endfunction

  function automatic void failure(input string msg);
    errors++;
    $display("%s (at %0t ns)", msg, $time);
  endfunction

  function automatic void open_test(input string name);
    cur_test = name;
    errors_at_open = errors;
  endfunction

  function automatic void close_test();
    tests_run++;
    if (errors == errors_at_open) begin
      $display("test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", cur_test, errors - errors_at_open);
    end
  endfunction

  function automatic void check_replies(input string what);
    assert (rx_q.size() == exp_q.size())
      else mismatch($sformatf("%s returned %0d bytes, expected %0d",
                              what, rx_q.size(), exp_q.size()));
    foreach (exp_q[i]) begin
      if (i < rx_q.size()) begin
        assert (rx_q[i] == exp_q[i])
          else mismatch($sformatf("%s reply byte %0d is %h, expected %h",
                                  what, i, rx_q[i], exp_q[i]));
      end
    end
    rx_q.delete();
    exp_q.delete();
  endfunction

  task automatic wait_replies(input int n);
    int waited;
    waited = 0;
    while (rx_q.size() < n && waited < (n + 2) * FRAME_CLKS) begin
      @(posedge clk);
      waited++;
    end
    if (rx_q.size() < n) begin
      failure($sformatf("timed out waiting for %0d reply bytes, only %0d came back",
                        n, rx_q.size()));
    end
  endtask

  // A stray extra byte would start inside this window
  task automatic settle_line();
    repeat (2 * FRAME_CLKS) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // Requests
  ////////////////////////////////////////

  task automatic write_block(input uart_dbg_pkg::dbg_addr_t addr, input int len);
    uart_dbg_pkg::mem_addr_t a;
    uart_dbg_pkg::byte_t     d;
    a = addr[7:0];
    issue_request(uart_dbg_pkg::CMD_WRITE, addr, 64'(len), 1'b1);
    wait_replies(1);
    for (int i = 0; i < len; i++) begin
      d = uart_dbg_pkg::byte_t'($urandom);
      model_mem[a] = d;
      a = a + 8'd1;
      send_byte(d);
    end
    wait_replies(2);
    settle_line();
    exp_q.push_back(uart_dbg_pkg::ACK);
    exp_q.push_back(uart_dbg_pkg::EOT);
    check_replies("write");
  endtask

  task automatic read_block(input uart_dbg_pkg::dbg_addr_t addr, input int len);
    uart_dbg_pkg::mem_addr_t a;
    a = addr[7:0];
    issue_request(uart_dbg_pkg::CMD_READ, addr, 64'(len), 1'b1);
    exp_q.push_back(uart_dbg_pkg::ACK);
    for (int i = 0; i < len; i++) begin
      exp_q.push_back(model_mem[a]);
      a = a + 8'd1;
    end
    exp_q.push_back(uart_dbg_pkg::EOT);
    wait_replies(len + 2);
    settle_line();
    check_replies("read");
  endtask

  task automatic run_exec(input uart_dbg_pkg::dbg_addr_t entry);
    int pulses_before;
    pulses_before = exec_cnt;
    exp_entry = entry;
    issue_request(uart_dbg_pkg::CMD_EXEC, entry, '0, 1'b0);
    wait_replies(1);
    settle_line();
    exp_q.push_back(uart_dbg_pkg::ACK);
    check_replies("exec");
    assert (exec_cnt == pulses_before + 1)
      else mismatch($sformatf("exec pulsed %0d times", exec_cnt - pulses_before));
    assert (exec_seen == entry)
      else mismatch($sformatf("exec entry %h, expected %h", exec_seen, entry));
  endtask

  ////////////////////////////////////////
  // Monitors and assertions
  ////////////////////////////////////////

  initial begin : reply_monitor
    uart_dbg_pkg::byte_t b;
    forever begin
      recv_byte(b);
      rx_q.push_back(b);
    end
  end

  always @(negedge clk) begin
    if (rst_n_i === 1'b1 && exec_valid_o === 1'b1) begin
      exec_cnt++;
      exec_seen = exec_addr_o;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i) exec_valid_o |=> !exec_valid_o)
    else mismatch("exec_valid_o high for more than one cycle");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    exec_valid_o |-> exec_addr_o == exp_entry)
    else mismatch("exec_addr_o differs from the entry at the launch pulse");

  // Idle line and no launch before the first command
  assert property (@(posedge clk) disable iff (!rst_n_i)
    quiet_expected |-> uart_tx_o && !exec_valid_o)
    else mismatch("output activity while the loader should be idle");

  initial begin : watchdog
    #(WATCH_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCH_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    int                      len;
    uart_dbg_pkg::dbg_addr_t addr;
    clk = 1'b0;
    rst_n_i <= 1'b0;
    uart_rx_i <= 1'b1;
    quiet_expected <= 1'b0;
    exp_entry = '0;
    void'($urandom(32'h5d2c_d4a5));
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;

    open_test("reset");
    quiet_expected <= 1'b1;
    repeat (3 * FRAME_CLKS) @(posedge clk);
    quiet_expected <= 1'b0;
    assert (rx_q.size() == 0 && exec_cnt == 0)
      else mismatch("reply or launch seen before the first command");
    close_test();

    // Unknown byte first, it must stay unanswered
    open_test("ack challenge");
    send_byte(8'h55);
    settle_line();
    check_replies("unknown byte");
    send_byte(uart_dbg_pkg::ACK);
    wait_replies(1);
    settle_line();
    exp_q.push_back(uart_dbg_pkg::ACK);
    check_replies("challenge");
    close_test();

    open_test("write");
    len = 1 + int'($urandom % MAX_LEN);
    addr = {32'($urandom), 32'($urandom)};
    write_block(addr, len);
    close_test();

    // Different upper address bits, same memory bytes
    open_test("read back");
    addr[63:8] = {32'($urandom), 24'($urandom)};
    read_block(addr, len);
    close_test();

    open_test("wrap");
    len = 8 + int'($urandom % 33);
    addr = {32'($urandom), 24'($urandom), 8'(256 - len / 2)};
    write_block(addr, len);
    addr[63:8] = {32'($urandom), 24'($urandom)};
    read_block(addr, len);
    close_test();

    open_test("zero length");
    addr = {32'($urandom), 32'($urandom)};
    write_block(addr, 0);
    read_block(addr, 0);
    close_test();

    open_test("exec");
    run_exec({32'($urandom), 32'($urandom)});
    close_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/uart_dbg_top.sv */
// UART debug loader top level
// Receiver, protocol engine, loader memory and transmitter.

`timescale 1ns/100ps
`default_nettype none

module uart_dbg_top (
  input  wire logic                clk,
  input  wire logic                rst_n_i,
  input  wire logic                uart_rx_i,
  output logic                     uart_tx_o,
  output logic                     exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t  exec_addr_o
);

  uart_dbg_pkg::byte_t     rx_data;
  logic                    rx_valid;
  uart_dbg_pkg::byte_t     tx_data;
  logic                    tx_start;
  logic                    tx_busy;
  logic                    mem_we;
  uart_dbg_pkg::mem_addr_t mem_addr;
  uart_dbg_pkg::byte_t     mem_wdata;
  uart_dbg_pkg::byte_t     mem_rdata;

  uart_rx i_uart_rx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_i       ( uart_rx_i ),
    .rx_data_o  ( rx_data   ),
    .rx_valid_o ( rx_valid  )
  );

  dbg_cmd_fsm i_dbg_cmd_fsm (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .rx_data_i    ( rx_data      ),
    .rx_valid_i   ( rx_valid     ),
    .tx_data_o    ( tx_data      ),
    .tx_start_o   ( tx_start     ),
    .tx_busy_i    ( tx_busy      ),
    .mem_we_o     ( mem_we       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_rdata_i  ( mem_rdata    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  dbg_mem i_dbg_mem (
    .clk     ( clk       ),
    .we_i    ( mem_we    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  uart_tx i_uart_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_data_i  ( tx_data   ),
    .tx_start_i ( tx_start  ),
    .tx_busy_o  ( tx_busy   ),
    .tx_o       ( uart_tx_o )
  );

endmodule

`default_nettype wire

/* design/dbg_cmd_fsm.sv */
// Debug loader protocol engine
// Decodes ACK challenge, read, write and exec requests from the
// receive byte stream. Collects the 64-bit address and length
// headers, moves data between UART and memory and sends the
// ACK and EOT replies. Exec gives a one-cycle launch pulse.

`timescale 1ns/100ps
`default_nettype none

module dbg_cmd_fsm (
  input  wire logic                    clk,
  input  wire logic                    rst_n_i,
  input  wire uart_dbg_pkg::byte_t     rx_data_i,
  input  wire logic                    rx_valid_i,
  output uart_dbg_pkg::byte_t          tx_data_o,
  output logic                         tx_start_o,
  input  wire logic                    tx_busy_i,
  output logic                         mem_we_o,
  output uart_dbg_pkg::mem_addr_t      mem_addr_o,
  output uart_dbg_pkg::byte_t          mem_wdata_o,
  input  wire uart_dbg_pkg::byte_t     mem_rdata_i,
  output logic                         exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t      exec_addr_o
);

  localparam int HDR_CNT_W = $clog2(uart_dbg_pkg::HDR_BYTES);
  localparam logic [HDR_CNT_W-1:0] HDR_LAST = HDR_CNT_W'(uart_dbg_pkg::HDR_BYTES - 1);
  // Only the low length bytes are kept
  localparam logic [HDR_CNT_W-1:0] LEN_KEEP = HDR_CNT_W'($bits(uart_dbg_pkg::len_t) / 8);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_LEN,
    S_ACK,
    S_WDATA,
    S_RADDR,
    S_RDATA,
    S_EOT
  } dbg_state_e;

  dbg_state_e               state_q;
  uart_dbg_pkg::byte_t      cmd_q;
  logic [HDR_CNT_W-1:0]     hdr_cnt_q;
  uart_dbg_pkg::dbg_addr_t  hdr_q;
  uart_dbg_pkg::len_t       len_q;
  uart_dbg_pkg::mem_addr_t  ptr_q;
  uart_dbg_pkg::len_t       remain_q;
  logic                     tx_free;

  assign tx_free = !tx_busy_i;

  ////////////////////////////////////////
  // Reply and memory side outputs
  ////////////////////////////////////////

  always_comb begin
    tx_start_o = 1'b0;
    tx_data_o  = uart_dbg_pkg::ACK;
    unique case (state_q)
      S_ACK: begin
        tx_start_o = tx_free;
      end
      S_RDATA: begin
        tx_start_o = tx_free;
        tx_data_o  = mem_rdata_i;
      end
      S_EOT: begin
        tx_start_o = tx_free;
        tx_data_o  = uart_dbg_pkg::EOT;
      end
      default: ;
    endcase
  end

  assign mem_we_o    = (state_q == S_WDATA) && rx_valid_i;
  assign mem_addr_o  = ptr_q;
  assign mem_wdata_o = rx_data_i;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= S_IDLE;
      cmd_q        <= '0;
      hdr_cnt_q    <= '0;
      ptr_q        <= '0;
      remain_q     <= '0;
      exec_valid_o <= 1'b0;
      exec_addr_o  <= '0;
    end else begin
      exec_valid_o <= 1'b0;
      unique case (state_q)
        S_IDLE: begin
          hdr_cnt_q <= '0;
          if (rx_valid_i) begin
            cmd_q <= rx_data_i;
            if (rx_data_i == uart_dbg_pkg::ACK) begin
              state_q <= S_ACK;
            end else if (rx_data_i == uart_dbg_pkg::CMD_READ ||
                         rx_data_i == uart_dbg_pkg::CMD_WRITE ||
                         rx_data_i == uart_dbg_pkg::CMD_EXEC) begin
              state_q <= S_ADDR;
            end
          end
        end
        S_ADDR: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == HDR_LAST) begin
              state_q <= (cmd_q == uart_dbg_pkg::CMD_EXEC) ? S_ACK : S_LEN;
            end
          end
        end
        S_LEN: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == HDR_LAST) begin
              state_q <= S_ACK;
            end
          end
        end
        // Reply ACK, then branch on the request
        S_ACK: begin
          if (tx_free) begin
            ptr_q    <= hdr_q[uart_dbg_pkg::MEM_ADDR_W-1:0];
            remain_q <= len_q;
            unique case (cmd_q)
              uart_dbg_pkg::CMD_EXEC: begin
                exec_valid_o <= 1'b1;
                exec_addr_o  <= hdr_q;
                state_q      <= S_IDLE;
              end
              uart_dbg_pkg::CMD_WRITE: begin
                state_q <= (len_q == '0) ? S_EOT : S_WDATA;
              end
              uart_dbg_pkg::CMD_READ: begin
                state_q <= (len_q == '0) ? S_EOT : S_RADDR;
              end
              default: state_q <= S_IDLE;
            endcase
          end
        end
        S_WDATA: begin
          if (rx_valid_i) begin
            ptr_q    <= ptr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            if (remain_q == uart_dbg_pkg::len_t'(1)) begin
              state_q <= S_EOT;
            end
          end
        end
        // One cycle for the registered memory read
        S_RADDR: begin
          state_q <= S_RDATA;
        end
        S_RDATA: begin
          if (tx_free) begin
            ptr_q    <= ptr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
            state_q  <= (remain_q == uart_dbg_pkg::len_t'(1)) ? S_EOT : S_RADDR;
          end
        end
        S_EOT: begin
          if (tx_free) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Header shift registers, LSB byte first
  always_ff @(posedge clk) begin
    if (state_q == S_ADDR && rx_valid_i) begin
      hdr_q <= {rx_data_i, hdr_q[63:8]};
    end
    if (state_q == S_LEN && rx_valid_i && hdr_cnt_q < LEN_KEEP) begin
      len_q <= {rx_data_i, len_q[15:8]};
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n_i)
    exec_valid_o |=> !exec_valid_o);

  // Writes only land inside a write transfer with bytes left
  assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_we_o |-> (cmd_q == uart_dbg_pkg::CMD_WRITE) && (remain_q != '0));

endmodule

`default_nettype wire

/* design/dbg_mem.sv */
// Loader memory
// 256 bytes with one synchronous write port and a registered
// read port. Contents are undefined until written.

`timescale 1ns/100ps
`default_nettype none

module dbg_mem (
  input  wire logic                    clk,
  input  wire logic                    we_i,
  input  wire uart_dbg_pkg::mem_addr_t addr_i,
  input  wire uart_dbg_pkg::byte_t     wdata_i,
  output uart_dbg_pkg::byte_t          rdata_o
);

  uart_dbg_pkg::byte_t mem_q [uart_dbg_pkg::MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Read data appears one cycle after the address
  always_ff @(posedge clk) begin
    rdata_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
// UART transmitter
// Sends one 8N1 frame per start strobe. Busy stays high for the
// whole frame, ten bit periods of line time.

`timescale 1ns/100ps
`default_nettype none

module uart_tx (
  input  wire logic                clk,
  input  wire logic                rst_n_i,
  input  wire uart_dbg_pkg::byte_t tx_data_i,
  input  wire logic                tx_start_i,
  output logic                     tx_busy_o,
  output logic                     tx_o
);

  localparam int CNT_W = $clog2(uart_dbg_pkg::CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(uart_dbg_pkg::CLKS_PER_BIT - 1);

  logic [CNT_W-1:0] baud_cnt_q;
  logic [3:0]       bit_cnt_q;
  // Remaining frame bits after the start bit: data then stop
  logic [8:0]       frame_q;
  logic             load;
  logic             bit_end;

  assign load    = tx_start_i && !tx_busy_o;
  assign bit_end = tx_busy_o && (baud_cnt_q == BIT_END);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_busy_o  <= 1'b0;
      tx_o       <= 1'b1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (load) begin
      tx_busy_o  <= 1'b1;
      tx_o       <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (bit_end) begin
      baud_cnt_q <= '0;
      bit_cnt_q  <= bit_cnt_q + 1'b1;
      if (bit_cnt_q == 4'd9) begin
        // Stop bit done, line already high
        tx_busy_o <= 1'b0;
      end else begin
        tx_o <= frame_q[0];
      end
    end else if (tx_busy_o) begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      frame_q <= {1'b1, tx_data_i};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[8:1]};
    end
  end

  // The engine must wait out a running frame before the next byte
  assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_start_i |-> !tx_busy_o);

endmodule

`default_nettype wire

/* design/uart_rx.sv */
// UART receiver
// 8N1 frames, line sampled in the middle of each bit. A one-cycle
// valid pulse marks each byte with a good stop bit.

`timescale 1ns/100ps
`default_nettype none

module uart_rx (
  input  wire logic                clk,
  input  wire logic                rst_n_i,
  input  wire logic                rx_i,
  output uart_dbg_pkg::byte_t      rx_data_o,
  output logic                     rx_valid_o
);

  localparam int CNT_W = $clog2(uart_dbg_pkg::CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(uart_dbg_pkg::CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(uart_dbg_pkg::CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e           state_q;
  logic                rx_meta_q;
  logic                rx_sync_q;
  logic [CNT_W-1:0]    baud_cnt_q;
  logic [2:0]          bit_cnt_q;
  uart_dbg_pkg::byte_t shift_q;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= RX_IDLE;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      unique case (state_q)
        RX_IDLE: begin
          baud_cnt_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        // Confirm start bit at mid-bit, else it was a glitch
        RX_START: begin
          if (baud_cnt_q == HALF_END) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            state_q    <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (baud_cnt_q == BIT_END) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (baud_cnt_q == BIT_END) begin
            baud_cnt_q <= '0;
            // A low stop bit is a framing error; the byte is dropped
            rx_valid_o <= rx_sync_q;
            state_q    <= RX_IDLE;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && baud_cnt_q == BIT_END) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_data_o = shift_q;

  // Consumer has no back-pressure, a held strobe would duplicate a byte
  assert property (@(posedge clk) disable iff (!rst_n_i)
    rx_valid_o |=> !rx_valid_o);

endmodule

`default_nettype wire

/* design/uart_dbg_pkg.sv */
// UART debug loader package
// Protocol bytes, serial bit timing, memory geometry and the
// vector types shared by the loader blocks.

`default_nettype none

package uart_dbg_pkg;

  ////////////////////////////////////////
  // Serial timing and geometry
  ////////////////////////////////////////

  // Clocks per serial bit, scaled down for simulation
  localparam int CLKS_PER_BIT = 16;

  localparam int MEM_DEPTH  = 256;
  localparam int MEM_ADDR_W = 8;

  // Bytes on the wire for each of address and length
  localparam int HDR_BYTES = 8;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [7:0]            byte_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [63:0]           dbg_addr_t;
  typedef logic [15:0]           len_t;

  ////////////////////////////////////////
  // Protocol bytes
  ////////////////////////////////////////

  localparam byte_t CMD_READ  = 8'h11;
  localparam byte_t CMD_WRITE = 8'h12;
  localparam byte_t CMD_EXEC  = 8'h13;
  localparam byte_t ACK       = 8'h06;
  localparam byte_t EOT       = 8'h04;

endpackage

`default_nettype wire
